// File: source/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and register file sizes
`define RV_XLEN             64
`define RV_ILEN             32
`define RV_NREGS            32
`define RV_RESET_PC         64'h0000_0000_0000_0000

// base opcodes, inst[6:0]
`define RV_OPC_OP           7'b0110011
`define RV_OPC_OP_IMM       7'b0010011
`define RV_OPC_LUI          7'b0110111
`define RV_OPC_LOAD         7'b0000011
`define RV_OPC_STORE        7'b0100011
`define RV_OPC_BRANCH       7'b1100011
`define RV_OPC_JAL          7'b1101111

// execute operation codes
`define RV_EXOP_NOP         4'd0
`define RV_EXOP_ADD         4'd1
`define RV_EXOP_SUB         4'd2
`define RV_EXOP_AND         4'd3
`define RV_EXOP_OR          4'd4
`define RV_EXOP_XOR         4'd5
`define RV_EXOP_LUI         4'd6
`define RV_EXOP_LD          4'd7
`define RV_EXOP_SD          4'd8
`define RV_EXOP_BEQ         4'd9
`define RV_EXOP_BNE         4'd10
`define RV_EXOP_JAL         4'd11

`endif

// File: source/rv_pkg.sv
`include "rv_params.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   xlen_t;
    typedef logic [`RV_ILEN-1:0]   inst_t;
    typedef logic [4:0]            reg_addr_t;
    typedef logic [`RV_XLEN/8-1:0] wmask_t;
    typedef logic [3:0]            ex_op_t;

    // fetch/decode register
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        inst_t inst;
    } fetch_pkt_t;

    // decode/execute register
    typedef struct packed {
        logic      valid;
        ex_op_t    op;
        xlen_t     pc;
        reg_addr_t rd;
        logic      reg_wen;
        xlen_t     op1;
        // rs2 or immediate
        xlen_t     op2;
        xlen_t     store_data;
        // branch, load and store offset
        xlen_t     imm;
    } decode_pkt_t;

    typedef struct packed {
        logic      wen;
        reg_addr_t addr;
        xlen_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic  en;
        xlen_t target;
    } jump_t;

    typedef struct packed {
        logic   en;
        xlen_t  addr;
        xlen_t  data;
        wmask_t mask;
    } dmem_wr_t;

endpackage

// File: source/inst_fetch.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module inst_fetch (
    input  logic               clk,
    input  logic               arst_n_i,

    // redirect from execute
    input  rv_pkg::jump_t      jump_i,

    // instruction memory, read in the same cycle
    output rv_pkg::xlen_t      inst_addr_o,
    input  rv_pkg::inst_t      inst_i,

    output rv_pkg::fetch_pkt_t fetch_o
);
    rv_pkg::xlen_t pc_q;
    rv_pkg::xlen_t pc_next;

    // sequential unless execute redirects
    assign pc_next = jump_i.en ? jump_i.target : pc_q + rv_pkg::xlen_t'(4);

    assign inst_addr_o = pc_q;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RV_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_o <= '0;
        end else if (jump_i.en) begin
            // wrong-path fetch, drop it
            fetch_o.valid <= 1'b0;
        end else begin
            fetch_o.valid <= 1'b1;
            fetch_o.pc    <= pc_q;
            fetch_o.inst  <= inst_i;
        end
    end

endmodule

// File: source/id.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module id (
    input  logic                clk,
    input  logic                arst_n_i,

    input  rv_pkg::fetch_pkt_t  fetch_i,
    input  logic                flush_i,

    // register file read
    output rv_pkg::reg_addr_t   rs1_addr_o,
    output rv_pkg::reg_addr_t   rs2_addr_o,
    input  rv_pkg::xlen_t       rs1_data_i,
    input  rv_pkg::xlen_t       rs2_data_i,

    output rv_pkg::decode_pkt_t decode_o
);
    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    rv_pkg::reg_addr_t   rd;
    rv_pkg::xlen_t       imm_i;
    rv_pkg::xlen_t       imm_s;
    rv_pkg::xlen_t       imm_b;
    rv_pkg::xlen_t       imm_u;
    rv_pkg::xlen_t       imm_j;
    rv_pkg::decode_pkt_t dec_d;

    assign opcode     = fetch_i.inst[6:0];
    assign rd         = fetch_i.inst[11:7];
    assign funct3     = fetch_i.inst[14:12];
    assign rs1_addr_o = fetch_i.inst[19:15];
    assign rs2_addr_o = fetch_i.inst[24:20];
    assign funct7     = fetch_i.inst[31:25];

    // sign-extended immediates
    assign imm_i = {{(`RV_XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:20]};
    assign imm_s = {{(`RV_XLEN-12){fetch_i.inst[31]}}, fetch_i.inst[31:25],
                    fetch_i.inst[11:7]};
    assign imm_b = {{(`RV_XLEN-13){fetch_i.inst[31]}}, fetch_i.inst[31], fetch_i.inst[7],
                    fetch_i.inst[30:25], fetch_i.inst[11:8], 1'b0};
    assign imm_u = {{(`RV_XLEN-32){fetch_i.inst[31]}}, fetch_i.inst[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-21){fetch_i.inst[31]}}, fetch_i.inst[31],
                    fetch_i.inst[19:12], fetch_i.inst[20], fetch_i.inst[30:21], 1'b0};

    always_comb begin
        dec_d            = '0;
        dec_d.valid      = fetch_i.valid;
        dec_d.op         = `RV_EXOP_NOP;
        dec_d.pc         = fetch_i.pc;
        dec_d.rd         = rd;
        dec_d.op1        = rs1_data_i;
        dec_d.op2        = rs2_data_i;
        dec_d.store_data = rs2_data_i;
        dec_d.imm        = imm_i;

        case (opcode)
            `RV_OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec_d.op = `RV_EXOP_ADD;
                        3'b100:  dec_d.op = `RV_EXOP_XOR;
                        3'b110:  dec_d.op = `RV_EXOP_OR;
                        3'b111:  dec_d.op = `RV_EXOP_AND;
                        default: dec_d.op = `RV_EXOP_NOP;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec_d.op = `RV_EXOP_SUB;
                end
            end
            `RV_OPC_OP_IMM: begin
                // only addi
                if (funct3 == 3'b000) begin
                    dec_d.op  = `RV_EXOP_ADD;
                    dec_d.op2 = imm_i;
                end
            end
            `RV_OPC_LUI: begin
                dec_d.op  = `RV_EXOP_LUI;
                dec_d.imm = imm_u;
            end
            `RV_OPC_LOAD: begin
                // doubleword only
                if (funct3 == 3'b011) begin
                    dec_d.op = `RV_EXOP_LD;
                end
            end
            `RV_OPC_STORE: begin
                if (funct3 == 3'b011) begin
                    dec_d.op  = `RV_EXOP_SD;
                    dec_d.imm = imm_s;
                end
            end
            `RV_OPC_BRANCH: begin
                dec_d.imm = imm_b;
                if (funct3 == 3'b000) begin
                    dec_d.op = `RV_EXOP_BEQ;
                end else if (funct3 == 3'b001) begin
                    dec_d.op = `RV_EXOP_BNE;
                end
            end
            `RV_OPC_JAL: begin
                dec_d.op  = `RV_EXOP_JAL;
                dec_d.imm = imm_j;
            end
            default: dec_d.op = `RV_EXOP_NOP;
        endcase

        // ops with a result for rd
        dec_d.reg_wen = dec_d.op inside {`RV_EXOP_ADD, `RV_EXOP_SUB, `RV_EXOP_AND,
                                         `RV_EXOP_OR, `RV_EXOP_XOR, `RV_EXOP_LUI,
                                         `RV_EXOP_LD, `RV_EXOP_JAL};
    end

    // decode/execute register
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            decode_o <= '0;
        end else if (flush_i || !fetch_i.valid) begin
            decode_o.valid   <= 1'b0;
            decode_o.op      <= `RV_EXOP_NOP;
            decode_o.reg_wen <= 1'b0;
        end else begin
            decode_o <= dec_d;
        end
    end

endmodule

// File: source/regs.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module regs (
    input  logic              clk,
    input  logic              arst_n_i,

    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    output rv_pkg::xlen_t     rs1_data_o,
    output rv_pkg::xlen_t     rs2_data_o,

    // write-back from execute
    input  rv_pkg::reg_wr_t   wr_i
);
    rv_pkg::xlen_t regs_q [`RV_NREGS];

    // x0 reads zero, a same-cycle write is forwarded
    function automatic rv_pkg::xlen_t read_port(input rv_pkg::reg_addr_t addr,
                                                input rv_pkg::xlen_t stored);
        if (addr == '0) begin
            return '0;
        end else if (wr_i.wen && wr_i.addr == addr) begin
            return wr_i.data;
        end
        return stored;
    endfunction

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.wen && wr_i.addr != '0) begin
            regs_q[wr_i.addr] <= wr_i.data;
        end
    end

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i, regs_q[rs1_addr_i]);
        rs2_data_o = read_port(rs2_addr_i, regs_q[rs2_addr_i]);
    end

endmodule

// File: source/ex.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module ex (
    input  rv_pkg::decode_pkt_t decode_i,

    // register write-back
    output rv_pkg::reg_wr_t     wr_o,

    // redirect to fetch, also flushes both pipeline registers
    output rv_pkg::jump_t       jump_o,

    // data memory
    output logic                mem_ren_o,
    output rv_pkg::xlen_t       mem_raddr_o,
    input  rv_pkg::xlen_t       mem_rdata_i,
    output rv_pkg::dmem_wr_t    mem_wr_o
);
    rv_pkg::xlen_t ls_addr;
    rv_pkg::xlen_t target;
    rv_pkg::xlen_t link;
    rv_pkg::xlen_t result;
    logic          taken;

    assign ls_addr = decode_i.op1 + decode_i.imm;
    assign target  = decode_i.pc + decode_i.imm;
    assign link    = decode_i.pc + rv_pkg::xlen_t'(4);

    always_comb begin
        case (decode_i.op)
            `RV_EXOP_ADD: result = decode_i.op1 + decode_i.op2;
            `RV_EXOP_SUB: result = decode_i.op1 - decode_i.op2;
            `RV_EXOP_AND: result = decode_i.op1 & decode_i.op2;
            `RV_EXOP_OR:  result = decode_i.op1 | decode_i.op2;
            `RV_EXOP_XOR: result = decode_i.op1 ^ decode_i.op2;
            `RV_EXOP_LUI: result = decode_i.imm;
            `RV_EXOP_LD:  result = mem_rdata_i;
            `RV_EXOP_JAL: result = link;
            default:      result = '0;
        endcase
    end

    // branch resolution
    always_comb begin
        case (decode_i.op)
            `RV_EXOP_BEQ: taken = (decode_i.op1 == decode_i.op2);
            `RV_EXOP_BNE: taken = (decode_i.op1 != decode_i.op2);
            `RV_EXOP_JAL: taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    assign jump_o.en     = decode_i.valid & taken;
    assign jump_o.target = target;

    assign wr_o.wen  = decode_i.valid & decode_i.reg_wen;
    assign wr_o.addr = decode_i.rd;
    assign wr_o.data = result;

    // load, data returns in this cycle
    assign mem_ren_o   = decode_i.valid & (decode_i.op == `RV_EXOP_LD);
    assign mem_raddr_o = ls_addr;

    // one-cycle store strobe, full doubleword
    assign mem_wr_o.en   = decode_i.valid & (decode_i.op == `RV_EXOP_SD);
    assign mem_wr_o.addr = ls_addr;
    assign mem_wr_o.data = decode_i.store_data;
    assign mem_wr_o.mask = '1;

endmodule

// File: source/riscv.sv
`timescale 1ns/10ps

module riscv (
    input  logic                clk,
    input  logic                arst_n_i,

    // instruction memory
    output rv_pkg::xlen_t       inst_addr_o,
    input  rv_pkg::inst_t       inst_i,

    // data memory
    output logic                mem_ren_o,
    output rv_pkg::xlen_t       mem_raddr_o,
    input  rv_pkg::xlen_t       mem_rdata_i,
    output rv_pkg::dmem_wr_t    mem_wr_o,

    // flush indication
    output logic                hold_flag_o
);
    rv_pkg::jump_t       ex_jump;
    rv_pkg::fetch_pkt_t  if_fetch;
    rv_pkg::decode_pkt_t id_decode;
    rv_pkg::reg_addr_t   id_rs1_addr;
    rv_pkg::reg_addr_t   id_rs2_addr;
    rv_pkg::xlen_t       regs_rs1_data;
    rv_pkg::xlen_t       regs_rs2_data;
    rv_pkg::reg_wr_t     ex_wr;

    assign hold_flag_o = ex_jump.en;

    inst_fetch inst_fetch_inst (
        .clk         ( clk          ),
        .arst_n_i    ( arst_n_i     ),
        .jump_i      ( ex_jump      ),
        .inst_addr_o ( inst_addr_o  ),
        .inst_i      ( inst_i       ),
        .fetch_o     ( if_fetch     )
    );

    id id_inst (
        .clk         ( clk           ),
        .arst_n_i    ( arst_n_i      ),
        .fetch_i     ( if_fetch      ),
        .flush_i     ( ex_jump.en    ),
        .rs1_addr_o  ( id_rs1_addr   ),
        .rs2_addr_o  ( id_rs2_addr   ),
        .rs1_data_i  ( regs_rs1_data ),
        .rs2_data_i  ( regs_rs2_data ),
        .decode_o    ( id_decode     )
    );

    regs regs_inst (
        .clk         ( clk           ),
        .arst_n_i    ( arst_n_i      ),
        .rs1_addr_i  ( id_rs1_addr   ),
        .rs2_addr_i  ( id_rs2_addr   ),
        .rs1_data_o  ( regs_rs1_data ),
        .rs2_data_o  ( regs_rs2_data ),
        .wr_i        ( ex_wr         )
    );

    ex ex_inst (
        .decode_i    ( id_decode     ),
        .wr_o        ( ex_wr         ),
        .jump_o      ( ex_jump       ),
        .mem_ren_o   ( mem_ren_o     ),
        .mem_raddr_o ( mem_raddr_o   ),
        .mem_rdata_i ( mem_rdata_i   ),
        .mem_wr_o    ( mem_wr_o      )
    );

endmodule

// File: dv/tb_riscv.sv
`timescale 1ns/10ps
`include "rv_params.svh"

module tb_riscv;

    localparam rv_pkg::inst_t nop_inst = 32'h0000_0013;
    localparam int store_timeout = 1000;

    logic                clk;
    logic                arst_n_i;
    rv_pkg::xlen_t       inst_addr_o;
    rv_pkg::inst_t       inst_i;
    logic                mem_ren_o;
    rv_pkg::xlen_t       mem_raddr_o;
    rv_pkg::xlen_t       mem_rdata_i;
    rv_pkg::dmem_wr_t    mem_wr_o;
    logic                hold_flag_o;

    // 1 KB of program, 2 KB of data
    rv_pkg::inst_t       imem [256];
    rv_pkg::xlen_t       dmem [256];
    rv_pkg::dmem_wr_t    exp_st [$];
    rv_pkg::xlen_t       exp_jump [$];
    int                  st_idx = 0;
    int                  jump_idx = 0;
    logic                jump_seen = 1'b0;

    riscv riscv_inst (
        .clk         ( clk         ),
        .arst_n_i    ( arst_n_i    ),
        .inst_addr_o ( inst_addr_o ),
        .inst_i      ( inst_i      ),
        .mem_ren_o   ( mem_ren_o   ),
        .mem_raddr_o ( mem_raddr_o ),
        .mem_rdata_i ( mem_rdata_i ),
        .mem_wr_o    ( mem_wr_o    ),
        .hold_flag_o ( hold_flag_o )
    );

    always #5 clk = ~clk;

    // both memories answer in the same cycle
    assign inst_i      = (inst_addr_o < 64'd1024) ? imem[inst_addr_o[9:2]] : nop_inst;
    assign mem_rdata_i = mem_ren_o ? dmem[mem_raddr_o[10:3]] : '0;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_xlen(input string name, input rv_pkg::xlen_t exp_val,
                                input rv_pkg::xlen_t act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    task automatic compare_mask(input string name, input rv_pkg::wmask_t exp_val,
                                input rv_pkg::wmask_t act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            abort_run($sformatf("MISMATCH %s expected %h actual %h", name, exp_val, act_val));
        end
    endtask

    // in-order check against the expected list, then memory update
    task automatic check_store(input rv_pkg::dmem_wr_t wr);
        rv_pkg::dmem_wr_t exp_wr;
        if (st_idx >= exp_st.size()) begin
            abort_run($sformatf("unexpected store to address %h with data %h",
                                wr.addr, wr.data));
        end else begin
            exp_wr = exp_st[st_idx];
            compare_xlen("mem_wr_o.addr", exp_wr.addr, wr.addr);
            compare_xlen("mem_wr_o.data", exp_wr.data, wr.data);
            compare_mask("mem_wr_o.mask", exp_wr.mask, wr.mask);
            for (int b = 0; b < 8; b++) begin
                if (wr.mask[b]) begin
                    dmem[wr.addr[10:3]][8*b +: 8] = wr.data[8*b +: 8];
                end
            end
            st_idx++;
        end
    endtask

    task automatic load_testdata();
        int            fd;
        int            code;
        int            ch;
        logic [7:0]    tag;
        rv_pkg::xlen_t addr;
        rv_pkg::xlen_t data;
        rv_pkg::inst_t word;
        rv_pkg::wmask_t mask;
        fd = $fopen("dv/riscv_testdata.hex", "r");
        if (fd == 0) begin
            abort_run("cannot open the test data file dv/riscv_testdata.hex");
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            case (tag)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "I": begin
                    code = $fscanf(fd, "%h %h", addr, word);
                    if (code != 2) begin
                        abort_run("an instruction line in the test data file is incomplete");
                    end else begin
                        imem[addr[9:2]] = word;
                    end
                end
                "D": begin
                    code = $fscanf(fd, "%h %h", addr, data);
                    if (code != 2) begin
                        abort_run("a data line in the test data file is incomplete");
                    end else begin
                        dmem[addr[10:3]] = data;
                    end
                end
                "J": begin
                    code = $fscanf(fd, "%h", addr);
                    if (code != 1) begin
                        abort_run("a jump target line in the test data file is incomplete");
                    end else begin
                        exp_jump.push_back(addr);
                    end
                end
                "E": begin
                    code = $fscanf(fd, "%h %h %h", addr, data, mask);
                    if (code != 3) begin
                        abort_run("an expected store line in the test data file is incomplete");
                    end else begin
                        exp_st.push_back('{en: 1'b1, addr: addr, data: data, mask: mask});
                    end
                end
                default: abort_run("unknown record type in the test data file");
            endcase
        end
        $fclose(fd);
    endtask

    // stores, and the fetch address right after each taken jump
    always @(posedge clk) begin
        if (mem_wr_o.en) begin
            check_store(mem_wr_o);
        end
        if (jump_seen && jump_idx < exp_jump.size()) begin
            compare_xlen("inst_addr_o", exp_jump[jump_idx], inst_addr_o);
            jump_idx++;
        end
        jump_seen = hold_flag_o;
    end

    initial begin
        int          cycles;
        clk = 1'b0;
        arst_n_i <= 1'b0;
        void'($urandom(67));
        for (int i = 0; i < 256; i++) begin
            imem[i] = nop_inst;
            dmem[i] = {$urandom(), $urandom()};
        end
        load_testdata();

        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            compare_bit("mem_wr_o.en", 1'b0, mem_wr_o.en);
            compare_bit("mem_ren_o", 1'b0, mem_ren_o);
            compare_bit("hold_flag_o", 1'b0, hold_flag_o);
            compare_xlen("inst_addr_o", `RV_RESET_PC, inst_addr_o);
        end
        arst_n_i <= 1'b1;

        // first fetch after release
        @(posedge clk);
        compare_bit("mem_wr_o.en", 1'b0, mem_wr_o.en);
        compare_bit("mem_ren_o", 1'b0, mem_ren_o);
        compare_bit("hold_flag_o", 1'b0, hold_flag_o);
        compare_xlen("inst_addr_o", `RV_RESET_PC, inst_addr_o);

        cycles = 0;
        while (st_idx < exp_st.size()) begin
            @(negedge clk);
            cycles++;
            if (cycles > store_timeout) begin
                abort_run($sformatf("timeout after %0d cycles with %0d of %0d stores seen",
                                    cycles, st_idx, exp_st.size()));
            end
        end

        // self-jump must stay silent
        repeat (50) @(negedge clk);

        if (st_idx == exp_st.size() && jump_idx == exp_jump.size()) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("not every expected store or jump target was observed");
        end
    end

endmodule

// File: sim.f
+incdir+source
source/rv_pkg.sv
source/inst_fetch.sv
source/id.sv
source/regs.sv
source/ex.sv
source/riscv.sv
dv/tb_riscv.sv

// File: dv/riscv_testdata.hex
# I addr word = program, D addr data = initial data, J target = redirect pc in order
# E addr data mask = expected store in program order
I 00 12300093
I 04 10103023
I 08 12345137
I 0c 001101b3
I 10 40118233
I 14 10303423
I 18 10403823
I 1c fff00293
I 20 0032f333
I 24 005343b3
I 28 0013e433
I 2c 10703c23
I 30 12803023
# load then use, 0x308 left to random fill
I 34 30003483
I 38 00148513
I 3c 12a03423
I 40 30803583
I 44 05558613
I 48 40b606b3
I 4c 12d03823
# taken beq and bne skip two stores each
I 50 00618663
I 54 12103c23
I 58 12103c23
I 5c 00009663
I 60 12103c23
I 64 12103c23
I 68 00008663
I 6c 14903023
I 70 00619663
I 74 14203423
I 78 0100076f
I 7c 12103c23
I 80 12103c23
I 88 14e03823
I 8c 0000006f
D 300 0123456789abcdef
J 5c
J 68
J 88
J 8c
E 100 0000000000000123 ff
E 108 0000000012345123 ff
E 110 0000000012345000 ff
E 118 ffffffffedcbaedc ff
E 120 ffffffffedcbafff ff
E 128 0123456789abcdf0 ff
E 130 0000000000000055 ff
E 140 0123456789abcdef ff
E 148 0000000012345000 ff
E 150 000000000000007c ff
